// ==== ls_pkg.sv ====
`default_nettype none

package ls_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_COUNT  = 32;
    localparam int REG_IDX_W  = 5;

    // operation queue sizing
    localparam int OPQ_DEPTH  = 4;
    localparam int OPQ_PTR_W  = $clog2(OPQ_DEPTH);
    localparam int OPQ_CNT_W  = $clog2(OPQ_DEPTH + 1);

    // data memory, word addressed through addr[9:2]
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);
    localparam int DMEM_WAIT  = 2;     // request to hit, in cycles
    localparam int WAIT_CNT_W = $clog2(DMEM_WAIT + 1);

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] regbits_t;

    typedef enum logic [1:0] {
        MEM_NONE,
        LOAD,
        STORE
    } mem_type_t;

    // completion kind reported by the load/store unit
    typedef enum logic [1:0] {
        dhit_na,
        dhit_load,
        dhit_store
    } dhit_t;

endpackage

`default_nettype wire

// ==== op_queue.sv ====
`default_nettype none

module op_queue (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              push,
    input  logic              pop,
    input  ls_pkg::mem_type_t in_mem_type,
    input  ls_pkg::regbits_t  in_rs1,
    input  ls_pkg::regbits_t  in_rs2,
    input  ls_pkg::regbits_t  in_rd,
    input  ls_pkg::word_t     in_imm,
    output logic              full,
    output logic              empty,
    output ls_pkg::mem_type_t out_mem_type,
    output ls_pkg::regbits_t  out_rs1,
    output ls_pkg::regbits_t  out_rs2,
    output ls_pkg::regbits_t  out_rd,
    output ls_pkg::word_t     out_imm
);

    ls_pkg::mem_type_t type_q [ls_pkg::OPQ_DEPTH];
    ls_pkg::regbits_t  rs1_q  [ls_pkg::OPQ_DEPTH];
    ls_pkg::regbits_t  rs2_q  [ls_pkg::OPQ_DEPTH];
    ls_pkg::regbits_t  rd_q   [ls_pkg::OPQ_DEPTH];
    ls_pkg::word_t     imm_q  [ls_pkg::OPQ_DEPTH];

    logic [ls_pkg::OPQ_PTR_W-1:0] wr_ptr, rd_ptr;
    logic [ls_pkg::OPQ_CNT_W-1:0] count;
    logic do_push, do_pop;

    assign full    = (count == ls_pkg::OPQ_DEPTH);
    assign empty   = (count == '0);
    assign do_push = push && !full;    // push on full is dropped
    assign do_pop  = pop && !empty;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (do_push)
                wr_ptr <= (wr_ptr == ls_pkg::OPQ_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == ls_pkg::OPQ_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

    // entry storage
    always_ff @(posedge CLK) begin
        if (do_push) begin
            type_q[wr_ptr] <= in_mem_type;
            rs1_q[wr_ptr]  <= in_rs1;
            rs2_q[wr_ptr]  <= in_rs2;
            rd_q[wr_ptr]   <= in_rd;
            imm_q[wr_ptr]  <= in_imm;
        end
    end

    assign out_mem_type = type_q[rd_ptr];
    assign out_rs1      = rs1_q[rd_ptr];
    assign out_rs2      = rs2_q[rd_ptr];
    assign out_rd       = rd_q[rd_ptr];
    assign out_imm      = imm_q[rd_ptr];

endmodule

`default_nettype wire

// ==== scalar_regfile.sv ====
`default_nettype none

module scalar_regfile (
    input  logic             CLK,
    input  logic             nRST,
    input  ls_pkg::regbits_t rs1_idx,
    input  ls_pkg::regbits_t rs2_idx,
    input  logic             wb_en,
    input  ls_pkg::regbits_t wb_idx,
    input  ls_pkg::word_t    wb_data,
    input  logic             pre_en,
    input  ls_pkg::regbits_t pre_idx,
    input  ls_pkg::word_t    pre_data,
    output ls_pkg::word_t    rs1_val,
    output ls_pkg::word_t    rs2_val
);

    ls_pkg::word_t regs [ls_pkg::REG_COUNT];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < ls_pkg::REG_COUNT; i++)
                regs[i] <= '0;
        end
        else begin
            if (pre_en && pre_idx != '0)
                regs[pre_idx] <= pre_data;
            // later assignment, so a write-back to the same index wins
            if (wb_en && wb_idx != '0)
                regs[wb_idx] <= wb_data;
        end
    end

    // r0 reads as zero
    assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

`default_nettype wire

// ==== ls_issue.sv ====
`default_nettype none

module ls_issue (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              q_empty,
    input  ls_pkg::mem_type_t q_mem_type,
    input  ls_pkg::regbits_t  q_rs1,
    input  ls_pkg::regbits_t  q_rs2,
    input  ls_pkg::regbits_t  q_rd,
    input  ls_pkg::word_t     q_imm,
    input  ls_pkg::dhit_t     dhit,
    output logic              q_pop,
    output logic              enable,
    output ls_pkg::mem_type_t mem_type,
    output ls_pkg::regbits_t  rs1_idx,
    output ls_pkg::regbits_t  rs2_idx,
    output ls_pkg::regbits_t  rd_in,
    output ls_pkg::word_t     imm
);

    typedef enum logic [1:0] {
        idle, active, cooldown
    } state_t;

    state_t state;
    logic   take;

    // head is still valid in the cycle q_pop goes out
    assign take = (state == idle) && !q_pop && !q_empty;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= idle;
            q_pop    <= 1'b0;
            enable   <= 1'b0;
            mem_type <= ls_pkg::MEM_NONE;
        end
        else begin
            q_pop <= 1'b0;
            case (state)
                idle: begin
                    if (q_pop) begin
                        if (mem_type != ls_pkg::MEM_NONE) begin
                            enable <= 1'b1;
                            state  <= active;
                        end    // MEM_NONE is dropped here
                    end
                    else if (take) begin
                        q_pop    <= 1'b1;
                        mem_type <= q_mem_type;
                    end
                end
                active: begin
                    if (dhit != ls_pkg::dhit_na) begin
                        enable <= 1'b0;
                        state  <= cooldown;
                    end
                end
                cooldown: state <= idle;    // unit needs enable low to re-arm
                default:  state <= idle;
            endcase
        end
    end

    // operand fields
    always_ff @(posedge CLK) begin
        if (take) begin
            rs1_idx <= q_rs1;
            rs2_idx <= q_rs2;
            rd_in   <= q_rd;
            imm     <= q_imm;
        end
    end

endmodule

`default_nettype wire

// ==== scalar_ls_unit.sv ====
`default_nettype none

module scalar_ls_unit (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              enable,
    input  ls_pkg::mem_type_t mem_type,
    input  ls_pkg::word_t     rs1,
    input  ls_pkg::word_t     rs2,
    input  ls_pkg::word_t     imm,
    input  ls_pkg::regbits_t  rd_in,
    input  logic              dhit_in,
    input  ls_pkg::word_t     dmem_in,
    output ls_pkg::word_t     dmemaddr,
    output ls_pkg::word_t     dmemstore,
    output ls_pkg::word_t     dmemload,
    output logic              dmemREN,
    output logic              dmemWEN,
    output ls_pkg::dhit_t     dhit,
    output ls_pkg::regbits_t  rd
);

    typedef enum logic {
        idle, latched
    } state_t;

    state_t state, next_state;

    ls_pkg::word_t    addr, latched_addr, next_addr;
    ls_pkg::word_t    latched_store, next_store;
    ls_pkg::regbits_t latched_rd, next_rd;
    logic latched_ren, next_ren, latched_wen, next_wen;
    logic latched_enable, start;

    assign addr  = imm + rs1;
    assign start = enable && !latched_enable;    // new work on enable rise

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state          <= idle;
            latched_enable <= 1'b0;
            latched_addr   <= '0;
            latched_store  <= '0;
            latched_ren    <= 1'b0;
            latched_wen    <= 1'b0;
            latched_rd     <= '0;
        end
        else begin
            state          <= next_state;
            latched_enable <= enable;
            latched_addr   <= next_addr;
            latched_store  <= next_store;
            latched_ren    <= next_ren;
            latched_wen    <= next_wen;
            latched_rd     <= next_rd;
        end
    end

    // request capture
    always_comb begin
        next_addr  = latched_addr;
        next_store = latched_store;
        next_ren   = latched_ren;
        next_wen   = latched_wen;
        next_rd    = latched_rd;
        if (start) begin
            next_addr  = addr;
            next_store = rs2;
            next_ren   = (mem_type == ls_pkg::LOAD);
            next_wen   = (mem_type == ls_pkg::STORE);
            next_rd    = rd_in;
        end
    end

    // memory drive and completion
    always_comb begin
        next_state = state;
        dmemaddr   = '0;
        dmemstore  = '0;
        dmemREN    = 1'b0;
        dmemWEN    = 1'b0;
        dmemload   = '0;
        dhit       = ls_pkg::dhit_na;
        rd         = '0;
        if (enable) begin
            case (state)
                idle: begin
                    // first cycle goes straight from the operands
                    if (start && (next_ren || next_wen)) begin
                        dmemaddr   = addr;
                        dmemREN    = next_ren;
                        dmemWEN    = next_wen;
                        dmemstore  = next_wen ? rs2 : '0;
                        next_state = latched;
                    end
                end
                latched: begin
                    dmemaddr  = latched_addr;
                    dmemstore = latched_store;
                    dmemREN   = latched_ren;    // held through the hit cycle
                    dmemWEN   = latched_wen;
                    if (dhit_in) begin
                        next_state = idle;
                        if (latched_ren) begin
                            dhit     = ls_pkg::dhit_load;
                            dmemload = dmem_in;
                            rd       = latched_rd;
                        end
                        else if (latched_wen)
                            dhit = ls_pkg::dhit_store;
                    end
                end
                default: next_state = idle;
            endcase
        end
        else
            next_state = idle;
    end

endmodule

`default_nettype wire

// ==== data_ram.sv ====
`default_nettype none

module data_ram (
    input  logic          CLK,
    input  logic          nRST,
    input  ls_pkg::word_t addr,
    input  logic          ren,
    input  logic          wen,
    input  ls_pkg::word_t wdata,
    output logic          hit,
    output ls_pkg::word_t rdata
);

    ls_pkg::word_t mem [ls_pkg::DMEM_WORDS];

    logic [ls_pkg::WAIT_CNT_W-1:0] wait_cnt;
    logic [ls_pkg::DMEM_IDX_W-1:0] idx;

    assign idx = addr[ls_pkg::DMEM_IDX_W+1:2];    // word index, byte bits dropped

    // hit from the counter only, the requester may react to it in the same cycle
    assign hit = (wait_cnt == ls_pkg::DMEM_WAIT);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
            for (int i = 0; i < ls_pkg::DMEM_WORDS; i++)
                mem[i] <= '0;
        end
        else if (hit) begin
            wait_cnt <= '0;
            if (wen)
                mem[idx] <= wdata;    // store commits on the hit
        end
        else if (ren || wen)
            wait_cnt <= wait_cnt + 1'b1;
    end

    assign rdata = (hit && ren) ? mem[idx] : '0;

endmodule

`default_nettype wire

// ==== ls_subsystem.sv ====
`default_nettype none

module ls_subsystem (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              op_push,
    input  ls_pkg::mem_type_t op_mem_type,
    input  ls_pkg::regbits_t  op_rs1,
    input  ls_pkg::regbits_t  op_rs2,
    input  ls_pkg::regbits_t  op_rd,
    input  ls_pkg::word_t     op_imm,
    input  logic              preload_wen,
    input  ls_pkg::regbits_t  preload_idx,
    input  ls_pkg::word_t     preload_data,
    output logic              queue_full,
    output logic              load_done,
    output logic              store_done,
    output ls_pkg::regbits_t  load_rd,
    output ls_pkg::word_t     load_data
);

    // queue head
    logic              q_pop, q_empty;
    ls_pkg::mem_type_t q_mem_type;
    ls_pkg::regbits_t  q_rs1, q_rs2, q_rd;
    ls_pkg::word_t     q_imm;

    // issue to unit and register file
    logic              enable;
    ls_pkg::mem_type_t mem_type;
    ls_pkg::regbits_t  rs1_idx, rs2_idx, rd_in;
    ls_pkg::word_t     imm, rs1_val, rs2_val;

    // unit outputs and memory reply
    ls_pkg::word_t     dmemaddr, dmemstore, dmemload, dmem_in;
    logic              dmemREN, dmemWEN, dhit_in;
    ls_pkg::dhit_t     dhit;
    ls_pkg::regbits_t  rd;

    op_queue op_queue_inst (
        .CLK(CLK), .nRST(nRST), .push(op_push), .pop(q_pop),
        .in_mem_type(op_mem_type), .in_rs1(op_rs1), .in_rs2(op_rs2),
        .in_rd(op_rd), .in_imm(op_imm), .full(queue_full), .empty(q_empty),
        .out_mem_type(q_mem_type), .out_rs1(q_rs1), .out_rs2(q_rs2),
        .out_rd(q_rd), .out_imm(q_imm)
    );

    ls_issue ls_issue_inst (
        .CLK(CLK), .nRST(nRST), .q_empty(q_empty), .q_mem_type(q_mem_type),
        .q_rs1(q_rs1), .q_rs2(q_rs2), .q_rd(q_rd), .q_imm(q_imm), .dhit(dhit),
        .q_pop(q_pop), .enable(enable), .mem_type(mem_type), .rs1_idx(rs1_idx),
        .rs2_idx(rs2_idx), .rd_in(rd_in), .imm(imm)
    );

    scalar_regfile scalar_regfile_inst (
        .CLK(CLK), .nRST(nRST), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
        .wb_en(load_done), .wb_idx(rd), .wb_data(dmemload),
        .pre_en(preload_wen), .pre_idx(preload_idx), .pre_data(preload_data),
        .rs1_val(rs1_val), .rs2_val(rs2_val)
    );

    scalar_ls_unit scalar_ls_unit_inst (
        .CLK(CLK), .nRST(nRST), .enable(enable), .mem_type(mem_type),
        .rs1(rs1_val), .rs2(rs2_val), .imm(imm), .rd_in(rd_in),
        .dhit_in(dhit_in), .dmem_in(dmem_in), .dmemaddr(dmemaddr),
        .dmemstore(dmemstore), .dmemload(dmemload), .dmemREN(dmemREN),
        .dmemWEN(dmemWEN), .dhit(dhit), .rd(rd)
    );

    data_ram data_ram_inst (
        .CLK(CLK), .nRST(nRST), .addr(dmemaddr), .ren(dmemREN), .wen(dmemWEN),
        .wdata(dmemstore), .hit(dhit_in), .rdata(dmem_in)
    );

    assign load_done  = (dhit == ls_pkg::dhit_load);
    assign store_done = (dhit == ls_pkg::dhit_store);
    assign load_rd    = rd;
    assign load_data  = dmemload;

endmodule

`default_nettype wire

// ==== tb_ls_subsystem.sv ====
`default_nettype none

module tb_ls_subsystem;

    localparam int REC_W    = 6;     // words per stimulus line
    localparam int MAX_RECS = 64;
    localparam int SETTLE   = 20;    // quiet cycles watched for stray completions

    // line kinds in ls_stimulus.txt
    localparam int K_END     = 0;
    localparam int K_PRELOAD = 1;
    localparam int K_OP      = 2;
    localparam int K_EXPECT  = 3;

    logic              CLK;
    logic              nRST;
    logic              op_push;
    ls_pkg::mem_type_t op_mem_type;
    ls_pkg::regbits_t  op_rs1, op_rs2, op_rd;
    ls_pkg::word_t     op_imm;
    logic              preload_wen;
    ls_pkg::regbits_t  preload_idx;
    ls_pkg::word_t     preload_data;
    logic              queue_full, load_done, store_done;
    ls_pkg::regbits_t  load_rd;
    ls_pkg::word_t     load_data;

    ls_pkg::word_t     stim [REC_W*MAX_RECS];
    int                pre_recs[$];
    int                op_recs[$];
    ls_pkg::mem_type_t kind_q[$];    // completion order, MEM_NONE left out
    ls_pkg::regbits_t  exp_rd_q[$];
    ls_pkg::word_t     exp_data_q[$];

    int     n_loads = 0;
    int     n_stores = 0;
    int     loads_seen = 0;
    int     stores_seen = 0;
    int     pushes = 0;
    int     value_errors = 0;
    int     other_errors = 0;
    int     cycle_count = 0;
    int     cycle_limit = 100;
    logic   full_seen = 1'b0;
    integer seed = 32'hd5d0_d5a8;

    event sampled;    // outputs taken, inputs may change now

    ls_subsystem ls_subsystem_inst (
        .CLK(CLK), .nRST(nRST), .op_push(op_push), .op_mem_type(op_mem_type),
        .op_rs1(op_rs1), .op_rs2(op_rs2), .op_rd(op_rd), .op_imm(op_imm),
        .preload_wen(preload_wen), .preload_idx(preload_idx),
        .preload_data(preload_data), .queue_full(queue_full),
        .load_done(load_done), .store_done(store_done), .load_rd(load_rd),
        .load_data(load_data)
    );

    always begin
        CLK = 1'b0;
        #4;
        CLK = 1'b1;
        #4;
    end

    task automatic check_word(input string name, input ls_pkg::word_t got,
                              input ls_pkg::word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %08h, expected %08h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_reg(input string name, input ls_pkg::regbits_t got,
                             input ls_pkg::regbits_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %02h, expected %02h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_kind(input string name, input ls_pkg::mem_type_t got,
                              input ls_pkg::mem_type_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %0h, expected %0h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic load_stimulus();
        int base;
        int kind;
        int n_load_ops;
        ls_pkg::mem_type_t mtype;
        n_load_ops = 0;
        for (int i = 0; i < REC_W*MAX_RECS; i++)
            stim[i] = '0;
        $readmemh("ls_stimulus.txt", stim);
        for (int r = 0; r < MAX_RECS; r++) begin
            base = r * REC_W;
            kind = stim[base];
            if (kind == K_END)
                break;
            case (kind)
                K_PRELOAD: pre_recs.push_back(base);
                K_OP: begin
                    op_recs.push_back(base);
                    mtype = ls_pkg::mem_type_t'(stim[base+1][1:0]);
                    if (mtype == ls_pkg::STORE)
                        n_stores++;
                    if (mtype == ls_pkg::LOAD)
                        n_load_ops++;
                    if (mtype != ls_pkg::MEM_NONE)
                        kind_q.push_back(mtype);
                end
                K_EXPECT: begin
                    exp_rd_q.push_back(stim[base+4][4:0]);
                    exp_data_q.push_back(stim[base+5]);
                    n_loads++;
                end
                default: begin
                    $display("stimulus line %0d has an unknown kind %0h", r, kind);
                    other_errors++;
                end
            endcase
        end
        if (n_load_ops != n_loads) begin
            $display("stimulus has %0d loads but %0d expected results", n_load_ops, n_loads);
            other_errors++;
        end
    endtask

    task automatic take_completion();
        ls_pkg::mem_type_t got_kind;
        got_kind = load_done ? ls_pkg::LOAD : ls_pkg::STORE;
        if (load_done && store_done) begin
            $display("load_done and store_done were high in the same cycle");
            other_errors++;
        end
        if (kind_q.size() == 0) begin
            $display("a completion arrived with no operation left to complete");
            other_errors++;
        end
        else
            check_kind("completion kind", got_kind, kind_q.pop_front());
        if (load_done) begin
            loads_seen++;
            if (exp_rd_q.size() == 0) begin
                $display("load_done arrived with no expected load result left");
                other_errors++;
            end
            else begin
                check_reg("load_rd", load_rd, exp_rd_q.pop_front());
                check_word("load_data", load_data, exp_data_q.pop_front());
            end
        end
        else
            stores_seen++;
    endtask

    // outputs are sampled mid-cycle, before the driver moves
    always @(negedge CLK) begin
        if (nRST === 1'b1) begin
            if (load_done || store_done)
                take_completion();
            if (queue_full) begin
                full_seen = 1'b1;
                if (pushes - loads_seen - stores_seen < ls_pkg::OPQ_DEPTH) begin
                    $display("queue_full rose with only %0d operations outstanding",
                             pushes - loads_seen - stores_seen);
                    other_errors++;
                end
            end
        end
        -> sampled;
    end

    task automatic apply_preload(input int base);
        @(sampled);
        preload_wen  = 1'b1;
        preload_idx  = stim[base+4][4:0];
        preload_data = stim[base+5];
        @(sampled);
        preload_wen  = 1'b0;
    endtask

    task automatic push_op(input int base);
        int gap;
        while (queue_full)
            @(sampled);
        op_mem_type = ls_pkg::mem_type_t'(stim[base+1][1:0]);
        op_rs1      = stim[base+2][4:0];
        op_rs2      = stim[base+3][4:0];
        op_rd       = stim[base+4][4:0];
        op_imm      = stim[base+5];
        op_push     = 1'b1;
        pushes++;
        @(sampled);
        op_push = 1'b0;
        gap = $random(seed) & 3;    // 0 to 3 idle cycles
        repeat (gap) @(sampled);
    endtask

    task automatic final_checks();
        if (stores_seen != n_stores) begin
            $display("saw %0d store completions, expected %0d", stores_seen, n_stores);
            other_errors++;
        end
        if (loads_seen != n_loads) begin
            $display("saw %0d load completions, expected %0d", loads_seen, n_loads);
            other_errors++;
        end
        if (!full_seen) begin
            $display("queue_full never rose while operations were pushed");
            other_errors++;
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    endtask

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles with %0d of %0d loads and %0d of %0d stores done",
                     cycle_count, loads_seen, n_loads, stores_seen, n_stores);
            other_errors++;
            finish_run();
        end
    end

    initial begin
        nRST         = 1'b0;
        op_push      = 1'b0;
        op_mem_type  = ls_pkg::MEM_NONE;
        op_rs1       = '0;
        op_rs2       = '0;
        op_rd        = '0;
        op_imm       = '0;
        preload_wen  = 1'b0;
        preload_idx  = '0;
        preload_data = '0;
        load_stimulus();
        cycle_limit = 20 * op_recs.size() + 100;
        repeat (4) @(posedge CLK);
        @(sampled);
        nRST = 1'b1;
        foreach (pre_recs[i])
            apply_preload(pre_recs[i]);
        foreach (op_recs[i])
            push_op(op_recs[i]);
        while (loads_seen < n_loads || stores_seen < n_stores)
            @(sampled);
        repeat (SETTLE) @(sampled);    // nothing more may complete
        final_checks();
        finish_run();
    end

endmodule

`default_nettype wire

// ==== ls_stimulus.txt ====
// kind type rs1 rs2 rd value, hex; kind 1 preload (rd = index), 2 operation, 3 expected load
// type 0 none, 1 load, 2 store; value is the immediate or the data; kind 0 ends the list
1 0 00 00 01 00000040
1 0 00 00 02 cafe0001
1 0 00 00 03 00000020
1 0 00 00 04 12345678
1 0 00 00 05 00000100
2 1 05 00 06 00000010
2 2 01 02 00 00000008
2 1 03 00 07 00000028
2 0 00 00 09 00000000
2 2 03 07 00 00000060
2 1 01 00 08 00000040
2 1 01 00 00 00000008
2 2 05 04 00 00000000
2 2 05 00 00 00000000
2 1 05 00 0a 00000000
2 0 01 02 03 00000004
2 2 03 04 00 00000004
2 1 01 00 0b ffffffe4
3 0 00 00 06 00000000
3 0 00 00 07 cafe0001
3 0 00 00 08 cafe0001
3 0 00 00 00 cafe0001
3 0 00 00 0a 00000000
3 0 00 00 0b 12345678
0 0 00 00 00 00000000

// ==== sources.f ====
ls_pkg.sv
op_queue.sv
scalar_regfile.sv
ls_issue.sv
scalar_ls_unit.sv
data_ram.sv
ls_subsystem.sv
tb_ls_subsystem.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_ls_subsystem
FILELIST  = sources.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
